// File: common/muldiv_pkg.sv
package muldiv_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------

  // width of operands and results
  localparam int XLEN = 32;

  // width of the transaction id issued with each request
  localparam int TRANS_ID_BITS = 3;

  // ----------------------------------------------------------
  // opcodes
  // ----------------------------------------------------------

  // multiply group in the lower half, divide group in the upper half
  typedef enum logic [2:0] {
    OP_MUL    = 3'b000,
    OP_MULH   = 3'b001,
    OP_MULHU  = 3'b010,
    OP_MULHSU = 3'b011,
    OP_DIV    = 3'b100,
    OP_DIVU   = 3'b101,
    OP_REM    = 3'b110,
    OP_REMU   = 3'b111
  } mul_op_e;

  // ----------------------------------------------------------
  // request and response
  // ----------------------------------------------------------

  // one issued request
  typedef struct packed {
    logic [TRANS_ID_BITS-1:0] trans_id;
    mul_op_e                  op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
  } fu_req_t;

  // one result, tagged with the id of its request
  typedef struct packed {
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          result;
  } fu_resp_t;

  // ----------------------------------------------------------
  // divider FSM
  // ----------------------------------------------------------

  // idle, load plus iterations, result waiting for the port
  typedef enum logic [1:0] {
    DIV_IDLE = 2'b00,
    DIV_RUN  = 2'b01,
    DIV_DONE = 2'b10
  } div_state_e;

endpackage

// File: compile.f
common/muldiv_pkg.sv
mult/multiplier.sv
mult/serdiv.sv
mult/mult.sv
src/muldiv_top.sv
test/muldiv_chk.sv
test/muldiv_scoreboard.sv
test/muldiv_tb.sv

// File: mult/mult.sv
module mult #(
  parameter int DIV_WIDTH = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // drops a running division and blocks issue
  input  logic                 flush_i,
  // request side
  input  logic                 req_valid_i,
  input  muldiv_pkg::fu_req_t  req_i,
  output logic                 req_ready_o,
  // result side, always accepted
  output logic                 resp_valid_o,
  output muldiv_pkg::fu_resp_t resp_o
);

  // opcode class of the request on the port
  logic is_mul;
  logic is_div;

  // issue valids
  logic mul_valid_op;
  logic div_valid_op;

  // multiplier result
  logic                 mul_valid;
  muldiv_pkg::fu_resp_t mul_resp;

  // divider side
  logic [DIV_WIDTH-1:0]                 div_op_a;
  logic [DIV_WIDTH-1:0]                 div_op_b;
  logic                                 div_rem;
  logic                                 div_signed;
  logic                                 div_in_rdy;
  logic                                 div_out_vld;
  logic                                 div_out_rdy;
  logic [muldiv_pkg::TRANS_ID_BITS-1:0] div_id;
  logic [DIV_WIDTH-1:0]                 div_res;

  // ----------------------------------------------------------
  // decode and issue
  // ----------------------------------------------------------

  assign is_mul = req_i.op inside {muldiv_pkg::OP_MUL, muldiv_pkg::OP_MULH,
                                   muldiv_pkg::OP_MULHU, muldiv_pkg::OP_MULHSU};
  assign is_div = req_i.op inside {muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU,
                                   muldiv_pkg::OP_REM, muldiv_pkg::OP_REMU};

  // the unit is ready only when the divider is idle
  assign req_ready_o = div_in_rdy;

  // multiply issues on a full handshake
  assign mul_valid_op = req_valid_i && req_ready_o && !flush_i && is_mul;
  // divide handshake completes inside the divider
  assign div_valid_op = req_valid_i && !flush_i && is_div;

  // signed variants and remainder variants
  assign div_signed = req_i.op inside {muldiv_pkg::OP_DIV, muldiv_pkg::OP_REM};
  assign div_rem    = req_i.op inside {muldiv_pkg::OP_REM, muldiv_pkg::OP_REMU};

  // silence divider operands unless a division is on the port
  always_comb begin
    div_op_a = '0;
    div_op_b = '0;
    if (req_valid_i && is_div) begin
      div_op_a = req_i.operand_a[DIV_WIDTH-1:0];
      div_op_b = req_i.operand_b[DIV_WIDTH-1:0];
    end
  end

  // ----------------------------------------------------------
  // multiply pipeline
  // ----------------------------------------------------------

  multiplier i_multiplier (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (mul_valid_op),
    .req_i   (req_i),
    .valid_o (mul_valid),
    .resp_o  (mul_resp)
  );

  // ----------------------------------------------------------
  // serial divider
  // ----------------------------------------------------------

  serdiv #(
    .WIDTH (DIV_WIDTH)
  ) i_serdiv (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .in_vld_i  (div_valid_op),
    .in_rdy_o  (div_in_rdy),
    .id_i      (req_i.trans_id),
    .op_a_i    (div_op_a),
    .op_b_i    (div_op_b),
    .rem_i     (div_rem),
    .signed_i  (div_signed),
    .out_vld_o (div_out_vld),
    .out_rdy_i (div_out_rdy),
    .id_o      (div_id),
    .res_o     (div_res)
  );

  // ----------------------------------------------------------
  // output arbitration
  // ----------------------------------------------------------

  // multiplier cannot stall so it always wins the port
  assign div_out_rdy = !mul_valid;

  assign resp_valid_o = mul_valid || div_out_vld;

  always_comb begin
    if (mul_valid) begin
      resp_o = mul_resp;
    end else begin
      // divider width equals XLEN at the top level
      resp_o.trans_id = div_id;
      resp_o.result   = div_res;
    end
  end

endmodule

// File: mult/multiplier.sv
module multiplier (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // request is a multiply and was accepted
  input  logic                 valid_i,
  input  muldiv_pkg::fu_req_t  req_i,
  // result valid, two stages after valid_i
  output logic                 valid_o,
  output muldiv_pkg::fu_resp_t resp_o
);

  // operand signedness implied by the opcode
  logic a_sign;
  logic b_sign;

  // stage one registers
  logic                                     valid_s1_q;
  logic signed [muldiv_pkg::XLEN:0]         a_s1_q;
  logic signed [muldiv_pkg::XLEN:0]         b_s1_q;
  logic [muldiv_pkg::TRANS_ID_BITS-1:0]     id_s1_q;
  logic                                     high_s1_q;

  // stage two registers
  logic                                     valid_s2_q;
  logic signed [2*muldiv_pkg::XLEN+1:0]     prod_s2_q;
  logic [muldiv_pkg::TRANS_ID_BITS-1:0]     id_s2_q;
  logic                                     high_s2_q;

  // ----------------------------------------------------------
  // operand extension
  // ----------------------------------------------------------

  // mulh is signed x signed, mulhsu signed x unsigned
  // mul and mulhu treat both as unsigned, the low word is the same
  always_comb begin
    a_sign = 1'b0;
    b_sign = 1'b0;
    case (req_i.op)
      muldiv_pkg::OP_MULH: begin
        a_sign = 1'b1;
        b_sign = 1'b1;
      end
      muldiv_pkg::OP_MULHSU: begin
        a_sign = 1'b1;
      end
      default: begin
        a_sign = 1'b0;
        b_sign = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------
  // pipeline
  // ----------------------------------------------------------

  // valid bits follow the data through both stages
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_s1_q <= 1'b0;
      valid_s2_q <= 1'b0;
    end else begin
      valid_s1_q <= valid_i;
      valid_s2_q <= valid_s1_q;
    end
  end

  // stage one takes the 33 bit operands and the word select
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      a_s1_q    <= {a_sign & req_i.operand_a[muldiv_pkg::XLEN-1], req_i.operand_a};
      b_s1_q    <= {b_sign & req_i.operand_b[muldiv_pkg::XLEN-1], req_i.operand_b};
      id_s1_q   <= req_i.trans_id;
      high_s1_q <= (req_i.op != muldiv_pkg::OP_MUL);
    end
  end

  // stage two holds the full 66 bit product
  always_ff @(posedge clk_i) begin
    if (valid_s1_q) begin
      prod_s2_q <= a_s1_q * b_s1_q;
      id_s2_q   <= id_s1_q;
      high_s2_q <= high_s1_q;
    end
  end

  // low word for mul, high word for the mulh variants
  assign valid_o         = valid_s2_q;
  assign resp_o.trans_id = id_s2_q;
  assign resp_o.result   = high_s2_q ? prod_s2_q[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN]
                                     : prod_s2_q[muldiv_pkg::XLEN-1:0];

endmodule

// File: mult/serdiv.sv
module serdiv #(
  parameter int WIDTH = 32
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // drops the division in progress
  input  logic                                 flush_i,
  // input handshake
  input  logic                                 in_vld_i,
  output logic                                 in_rdy_o,
  input  logic [muldiv_pkg::TRANS_ID_BITS-1:0] id_i,
  input  logic [WIDTH-1:0]                     op_a_i,
  input  logic [WIDTH-1:0]                     op_b_i,
  // opcode pair
  input  logic                                 rem_i,
  input  logic                                 signed_i,
  // output handshake
  output logic                                 out_vld_o,
  input  logic                                 out_rdy_i,
  output logic [muldiv_pkg::TRANS_ID_BITS-1:0] id_o,
  output logic [WIDTH-1:0]                     res_o
);

  // counts the load cycle and WIDTH iterations
  localparam int CNT_BITS = $clog2(WIDTH + 1);

  muldiv_pkg::div_state_e state_q;
  muldiv_pkg::div_state_e state_d;
  logic [CNT_BITS-1:0]    cnt_q;
  logic [CNT_BITS-1:0]    cnt_d;

  logic accept;
  logic load;

  // dividend shifts out of quo_q while quotient bits shift in
  logic [WIDTH-1:0]                     quo_q;
  logic [WIDTH-1:0]                     dvs_q;
  logic [WIDTH-1:0]                     rem_q;
  logic [muldiv_pkg::TRANS_ID_BITS-1:0] id_q;
  logic                                 rem_sel_q;
  logic                                 signed_q;
  logic                                 neg_quo_q;
  logic                                 neg_rem_q;

  // one restoring step
  logic [WIDTH:0]   rem_shift;
  logic [WIDTH:0]   diff;
  logic             step_bit;
  logic [WIDTH-1:0] step_rem;

  // magnitudes of the raw operands
  logic [WIDTH-1:0] abs_a;
  logic [WIDTH-1:0] abs_b;

  assign accept = in_vld_i && (state_q == muldiv_pkg::DIV_IDLE);
  assign load   = (state_q == muldiv_pkg::DIV_RUN) && (cnt_q == '0);

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      muldiv_pkg::DIV_IDLE: begin
        if (in_vld_i) begin
          state_d = muldiv_pkg::DIV_RUN;
          cnt_d   = '0;
        end
      end
      muldiv_pkg::DIV_RUN: begin
        cnt_d = cnt_q + 1'b1;
        // last iteration, result is ready next cycle
        if (cnt_q == CNT_BITS'(WIDTH)) begin
          state_d = muldiv_pkg::DIV_DONE;
        end
      end
      muldiv_pkg::DIV_DONE: begin
        // wait here while the multiplier owns the port
        if (out_rdy_i) begin
          state_d = muldiv_pkg::DIV_IDLE;
        end
      end
      default: begin
        state_d = muldiv_pkg::DIV_IDLE;
      end
    endcase
    // flush wins over everything
    if (flush_i) begin
      state_d = muldiv_pkg::DIV_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= muldiv_pkg::DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------

  assign abs_a = (signed_q && quo_q[WIDTH-1]) ? -quo_q : quo_q;
  assign abs_b = (signed_q && dvs_q[WIDTH-1]) ? -dvs_q : dvs_q;

  // bring in the next dividend bit and try the subtraction
  assign rem_shift = {rem_q, quo_q[WIDTH-1]};
  assign diff      = rem_shift - {1'b0, dvs_q};
  assign step_bit  = ~diff[WIDTH];
  assign step_rem  = step_bit ? diff[WIDTH-1:0] : rem_shift[WIDTH-1:0];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      // raw operands and opcode
      quo_q     <= op_a_i;
      dvs_q     <= op_b_i;
      id_q      <= id_i;
      rem_sel_q <= rem_i;
      signed_q  <= signed_i;
    end else if (load) begin
      // divide by zero keeps the quotient at all ones
      neg_quo_q <= signed_q && (quo_q[WIDTH-1] ^ dvs_q[WIDTH-1]) && (|dvs_q);
      // remainder follows the sign of the dividend
      neg_rem_q <= signed_q && quo_q[WIDTH-1];
      quo_q     <= abs_a;
      dvs_q     <= abs_b;
      rem_q     <= '0;
    end else if (state_q == muldiv_pkg::DIV_RUN) begin
      rem_q <= step_rem;
      quo_q <= {quo_q[WIDTH-2:0], step_bit};
    end
  end

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------

  assign in_rdy_o  = (state_q == muldiv_pkg::DIV_IDLE);
  assign out_vld_o = (state_q == muldiv_pkg::DIV_DONE);
  assign id_o      = id_q;

  // sign fix on the way out
  assign res_o = rem_sel_q ? (neg_rem_q ? -rem_q : rem_q)
                           : (neg_quo_q ? -quo_q : quo_q);

endmodule

// File: src/muldiv_top.sv
module muldiv_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  // request port
  input  logic                 req_valid_i,
  input  muldiv_pkg::fu_req_t  req_i,
  output logic                 req_ready_o,
  // response port, no back-pressure
  output logic                 resp_valid_o,
  output muldiv_pkg::fu_resp_t resp_o
);

  // divider runs at the full data path width
  mult #(
    .DIV_WIDTH (muldiv_pkg::XLEN)
  ) i_mult (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

endmodule

// File: test/muldiv_chk.sv
module muldiv_chk (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 flush_i,
  input logic                 req_valid_i,
  input muldiv_pkg::fu_req_t  req_i,
  input logic                 req_ready_i,
  input logic                 resp_valid_i,
  input muldiv_pkg::fu_resp_t resp_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // number of failed assertions in this instance
  int fail_cnt = 0;

  // a request waiting for ready keeps valid and all of its fields
  held_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else begin
      fail_cnt++;
      $error("request changed or dropped while waiting for ready");
    end

  // nothing comes out of the unit while it is held in reset
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !resp_valid_i)
    else begin
      fail_cnt++;
      $error("response valid during reset");
    end

  // every accepted multiply leaves the port two cycles later with its own id
  mul_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && req_ready_i && !flush_i &&
    (req_i.op inside {muldiv_pkg::OP_MUL, muldiv_pkg::OP_MULH,
                      muldiv_pkg::OP_MULHU, muldiv_pkg::OP_MULHSU})
    |-> ##2 resp_valid_i && (resp_i.trans_id == $past(req_i.trans_id, 2)))
    else begin
      fail_cnt++;
      $error("multiply result lost or late on the response port");
    end

  // issue reopens only after a division result was shown or a flush
  busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(req_ready_i) |-> $past(resp_valid_i || flush_i))
    else begin
      fail_cnt++;
      $error("request ready returned while the divider was still busy");
    end

endmodule

// File: test/muldiv_scoreboard.sv
module muldiv_scoreboard (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 flush_i,
  input logic                 req_valid_i,
  input logic                 req_ready_i,
  input muldiv_pkg::fu_req_t  req_i,
  input logic                 resp_valid_i,
  input muldiv_pkg::fu_resp_t resp_i
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int W   = muldiv_pkg::XLEN;
  localparam int IDS = 2 ** muldiv_pkg::TRANS_ID_BITS;

  // outstanding requests, indexed by trans_id
  bit                  pending    [IDS];
  muldiv_pkg::mul_op_e pend_op    [IDS];
  logic [W-1:0]        pend_res   [IDS];
  int                  pend_cycle [IDS];

  int cycle       = 0;
  int checked_cnt = 0;
  int error_cnt   = 0;
  int flushed_cnt = 0;

  // ----------------------------------------------------------
  // reference rules
  // ----------------------------------------------------------

  function automatic bit is_divide(muldiv_pkg::mul_op_e op);
    return op inside {muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU,
                      muldiv_pkg::OP_REM, muldiv_pkg::OP_REMU};
  endfunction

  // RISC-V M results, incl. divide by zero and signed overflow
  function automatic logic [W-1:0] expected_result(muldiv_pkg::mul_op_e op,
                                                   logic [W-1:0] a, logic [W-1:0] b);
    logic [2*W-1:0]      prod_uu;
    logic [2*W-1:0]      prod_ss;
    logic [2*W-1:0]      prod_su;
    logic signed [W-1:0] sq;
    logic signed [W-1:0] sr;
    logic                ovf;
    logic [W-1:0]        res;
    // 2W bit products modulo 2^2W, sign or zero extended first
    prod_uu = {{W{1'b0}}, a} * {{W{1'b0}}, b};
    prod_ss = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};
    prod_su = {{W{a[W-1]}}, a} * {{W{1'b0}}, b};
    sq      = $signed(a) / $signed(b);
    sr      = $signed(a) % $signed(b);
    // most negative dividend over minus one
    ovf     = (a == {1'b1, {(W-1){1'b0}}}) && (b == '1);
    case (op)
      muldiv_pkg::OP_MUL:    res = prod_uu[W-1:0];
      muldiv_pkg::OP_MULH:   res = prod_ss[2*W-1:W];
      muldiv_pkg::OP_MULHU:  res = prod_uu[2*W-1:W];
      muldiv_pkg::OP_MULHSU: res = prod_su[2*W-1:W];
      muldiv_pkg::OP_DIV:    res = (b == '0) ? '1 : (ovf ? a : sq);
      muldiv_pkg::OP_DIVU:   res = (b == '0) ? '1 : a / b;
      muldiv_pkg::OP_REM:    res = (b == '0) ? a : (ovf ? '0 : sr);
      default:               res = (b == '0) ? a : a % b;
    endcase
    return res;
  endfunction

  // ----------------------------------------------------------
  // per edge bookkeeping
  // ----------------------------------------------------------

  task automatic check_response();
    logic [muldiv_pkg::TRANS_ID_BITS-1:0] id;
    int                                   lat;
    id = resp_i.trans_id;
    if (!pending[id]) begin
      error_cnt++;
      $display("%0t response with trans_id %0d has no request outstanding", $time, id);
    end else begin
      lat         = cycle - pend_cycle[id];
      pending[id] = 1'b0;
      checked_cnt++;
      if (resp_i.result !== pend_res[id]) begin
        error_cnt++;
        $display("MISMATCH %0t resp_o.result id %0d %s expected %h actual %h",
                 $time, id, pend_op[id].name(), pend_res[id], resp_i.result);
      end else if (!is_divide(pend_op[id]) && lat != 2) begin
        error_cnt++;
        $display("%0t multiply id %0d returned after %0d cycles instead of 2",
                 $time, id, lat);
      end else begin
        $display("%0t id %0d %s result %h ok", $time, id, pend_op[id].name(),
                 resp_i.result);
      end
    end
  endtask

  // ready must stay low from acceptance until the division result is shown
  task automatic check_ready();
    bit busy;
    busy = 1'b0;
    for (int i = 0; i < IDS; i++) begin
      if (pending[i] && is_divide(pend_op[i])) begin
        busy = 1'b1;
      end
    end
    if (busy && req_ready_i) begin
      error_cnt++;
      $display("%0t req_ready_o is high while a division is in progress", $time);
    end
  endtask

  task automatic drop_divisions();
    for (int i = 0; i < IDS; i++) begin
      if (pending[i] && is_divide(pend_op[i])) begin
        pending[i] = 1'b0;
        flushed_cnt++;
        $display("%0t division id %0d dropped by flush", $time, i);
      end
    end
  endtask

  task automatic record_request();
    logic [muldiv_pkg::TRANS_ID_BITS-1:0] id;
    id = req_i.trans_id;
    if (pending[id]) begin
      error_cnt++;
      $display("%0t trans_id %0d issued again while still outstanding", $time, id);
    end
    pending[id]    = 1'b1;
    pend_op[id]    = req_i.op;
    pend_res[id]   = expected_result(req_i.op, req_i.operand_a, req_i.operand_b);
    pend_cycle[id] = cycle;
  endtask

  // results first, then flush, then the new request of this edge
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      cycle = 0;
      for (int i = 0; i < IDS; i++) begin
        pending[i] = 1'b0;
      end
    end else begin
      cycle++;
      if (resp_valid_i) begin
        check_response();
      end
      check_ready();
      if (flush_i) begin
        drop_divisions();
      end
      if (req_valid_i && req_ready_i && !flush_i) begin
        record_request();
      end
    end
  end

endmodule

// File: test/muldiv_stimulus.txt
// opcode  operand_a  operand_b  idle cycles before the request, all hex
// opcode 0 mul, 1 mulh, 2 mulhu, 3 mulhsu, 4 div, 5 divu, 6 rem, 7 remu
0 00000007 00000006 0
1 ffffffff 00000002 0
2 ffffffff ffffffff 0
3 80000000 ffffffff 0
1 80000000 80000000 0
0 12345678 9abcdef0 0
4 fffffff9 00000002 2
5 00000064 00000007 1
6 fffffff9 00000002 1
7 00000064 00000007 0
4 80000000 ffffffff 1
6 80000000 ffffffff 0
5 0000000a 00000000 2
6 fffffff6 00000000 0
4 00000064 fffffffb 1
0 00000003 fffffffd 0

// File: test/muldiv_tb.sv
module muldiv_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REQ    = 16;
  localparam int MAX_CYCLES = NUM_REQ * (muldiv_pkg::XLEN + 8) + 100;
  // requests 6 to 14 of the stimulus file are divisions
  localparam int FIRST_DIV  = 6;
  localparam int NUM_DIV    = 9;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 flush_i;
  logic                 req_valid_i;
  muldiv_pkg::fu_req_t  req_i;
  logic                 req_ready_o;
  logic                 resp_valid_o;
  muldiv_pkg::fu_resp_t resp_o;

  // four words per request: opcode, operand a, operand b, idle cycles
  logic [31:0] stim_mem [0:4*NUM_REQ-1];
  int          cycle_cnt = 0;
  int          issue_cnt = 0;
  int          flush_idx;

  muldiv_top UUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  muldiv_scoreboard i_scoreboard (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid_i),
    .req_ready_i  (req_ready_o),
    .req_i        (req_i),
    .resp_valid_i (resp_valid_o),
    .resp_i       (resp_o)
  );

  // handshake and arbitration assertions inside the unit
  bind mult muldiv_chk i_chk (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_i  (req_ready_o),
    .resp_valid_i (resp_valid_o),
    .resp_i       (resp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // timeout
  // ----------------------------------------------------------

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, %0d of %0d results seen",
             cycle_cnt, i_scoreboard.checked_cnt, NUM_REQ);
    $display("Finished with errors");
    $finish;
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------

  // called on a falling edge, returns on the falling edge after the handshake
  task automatic send_request(input int k);
    req_valid_i     = 1'b1;
    req_i.trans_id  = muldiv_pkg::TRANS_ID_BITS'(issue_cnt);
    req_i.op        = muldiv_pkg::mul_op_e'(stim_mem[4*k][2:0]);
    req_i.operand_a = stim_mem[4*k+1];
    req_i.operand_b = stim_mem[4*k+2];
    issue_cnt++;
    // ready is stable in the middle of the cycle
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
  endtask

  initial begin
    int idle;
    void'($urandom(43));
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    $readmemh("test/muldiv_stimulus.txt", stim_mem);
    flush_idx = FIRST_DIV + ($urandom % NUM_DIV);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int k = 0; k < NUM_REQ; k++) begin
      idle = stim_mem[4*k+3];
      // back-to-back lines keep their zero gap
      if (idle != 0) begin
        idle = idle + ($urandom % 3);
      end
      if (idle != 0) begin
        req_valid_i = 1'b0;
        repeat (idle) @(negedge clk_i);
      end
      send_request(k);
      if (k == flush_idx) begin
        // drop this division part way through, then issue it again
        req_valid_i = 1'b0;
        repeat (4 + ($urandom % 16)) @(negedge clk_i);
        $display("%0t flush during request %0d", $time, k);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        send_request(k);
      end
    end
    req_valid_i = 1'b0;
    while (i_scoreboard.checked_cnt < NUM_REQ) begin
      @(negedge clk_i);
    end
    // a few more cycles to catch stray responses
    repeat (5) @(negedge clk_i);
    $display("%0d results checked, %0d errors, %0d flushed, %0d assertion failures",
             i_scoreboard.checked_cnt, i_scoreboard.error_cnt,
             i_scoreboard.flushed_cnt, UUT.i_mult.i_chk.fail_cnt);
    if (i_scoreboard.error_cnt == 0 && UUT.i_mult.i_chk.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
